/* rtl/fabric.sv */
// 3x3 mesh of router tiles with neighbour links and local ports at the top
`timescale 1ns/100ps
`default_nettype none

module fabric
    import router_pkg::*;
#(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic        [GRID_DIM:1][GRID_DIM:1]  local_in_valid,
    input  t_tile_trans [GRID_DIM:1][GRID_DIM:1]  local_in_trans,
    input  t_fab_ready  [GRID_DIM:1][GRID_DIM:1]  local_out_ready,
    output t_fab_ready  [GRID_DIM:1][GRID_DIM:1]  local_in_ready,
    output logic        [GRID_DIM:1][GRID_DIM:1]  local_out_valid,
    output t_tile_trans [GRID_DIM:1][GRID_DIM:1]  local_out_trans
);

    localparam int EDGE = GRID_DIM + 1;

    // padded grid [col][row][port], ring cells stand in for the missing neighbours
    logic        [EDGE:0][EDGE:0][4:0] in_valid;
    t_tile_trans [EDGE:0][EDGE:0][4:0] in_trans;
    t_fab_ready  [EDGE:0][EDGE:0][4:0] in_ready;
    logic        [EDGE:0][EDGE:0][4:0] out_valid;
    t_tile_trans [EDGE:0][EDGE:0][4:0] out_trans;
    t_fab_ready  [EDGE:0][EDGE:0][4:0] out_ready;

    for (genvar COL = 0; COL <= EDGE; COL++) begin : g_col
        for (genvar ROW = 0; ROW <= EDGE; ROW++) begin : g_row
            if (COL == 0 || COL == EDGE || ROW == 0 || ROW == EDGE) begin : g_edge
                // nothing arrives from outside, anything sent out is taken
                assign out_valid[COL][ROW] = '0;
                assign out_trans[COL][ROW] = '0;
                assign in_ready[COL][ROW]  = '1;
            end else begin : g_tile
                localparam t_tile_id TILE_ID = '{col: 4'(COL), row: 4'(ROW)};

                // row above sits at ROW-1, column to the east at COL+1
                assign in_valid[COL][ROW][port_north]  = out_valid[COL][ROW-1][port_south];
                assign in_trans[COL][ROW][port_north]  = out_trans[COL][ROW-1][port_south];
                assign out_ready[COL][ROW][port_north] = in_ready[COL][ROW-1][port_south];
                assign in_valid[COL][ROW][port_south]  = out_valid[COL][ROW+1][port_north];
                assign in_trans[COL][ROW][port_south]  = out_trans[COL][ROW+1][port_north];
                assign out_ready[COL][ROW][port_south] = in_ready[COL][ROW+1][port_north];
                assign in_valid[COL][ROW][port_east]   = out_valid[COL+1][ROW][port_west];
                assign in_trans[COL][ROW][port_east]   = out_trans[COL+1][ROW][port_west];
                assign out_ready[COL][ROW][port_east]  = in_ready[COL+1][ROW][port_west];
                assign in_valid[COL][ROW][port_west]   = out_valid[COL-1][ROW][port_east];
                assign in_trans[COL][ROW][port_west]   = out_trans[COL-1][ROW][port_east];
                assign out_ready[COL][ROW][port_west]  = in_ready[COL-1][ROW][port_east];

                // local port straight to the top level
                assign in_valid[COL][ROW][port_local]  = local_in_valid[COL][ROW];
                assign in_trans[COL][ROW][port_local]  = local_in_trans[COL][ROW];
                assign out_ready[COL][ROW][port_local] = local_out_ready[COL][ROW];
                assign local_in_ready[COL][ROW]        = in_ready[COL][ROW][port_local];
                assign local_out_valid[COL][ROW]       = out_valid[COL][ROW][port_local];
                assign local_out_trans[COL][ROW]       = out_trans[COL][ROW][port_local];

                router_tile #(
                    .FIFO_DEPTH (FIFO_DEPTH)
                ) u_tile (
                    .clk           (clk),
                    .reset         (reset),
                    .local_tile_id (TILE_ID),
                    .in_valid      (in_valid[COL][ROW]),
                    .in_trans      (in_trans[COL][ROW]),
                    .out_ready     (out_ready[COL][ROW]),
                    .in_ready      (in_ready[COL][ROW]),
                    .out_valid     (out_valid[COL][ROW]),
                    .out_trans     (out_trans[COL][ROW])
                );
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/router_pkg.sv */
// tile id, opcode, transaction, port index and ready types for the mesh fabric
`default_nettype none

package router_pkg;

    // mesh is GRID_DIM x GRID_DIM tiles, ids run 1..GRID_DIM
    localparam int GRID_DIM = 3;

    typedef struct packed {
        logic [3:0] col;
        logic [3:0] row;
    } t_tile_id;

    // carried end to end, the fabric does not act on it
    typedef enum logic [1:0] {
        op_rd,
        op_wr,
        op_rd_rsp,
        op_wr_rsp
    } t_opcode;

    typedef struct packed {
        t_tile_id    target;
        t_tile_id    source;
        t_opcode     opcode;
        logic [15:0] address;
        logic [31:0] data;
        // per source sequence number
        logic [7:0]  seq;
    } t_tile_trans;

    // index into the five-entry port arrays of a tile
    typedef enum logic [2:0] {
        port_north,
        port_east,
        port_south,
        port_west,
        port_local
    } t_port;

    // ready level travelling against valid
    typedef logic t_fab_ready;

endpackage

`default_nettype wire

/* rtl/router_tile.sv */
// one mesh node: five input buffers, switch and five output registers
`timescale 1ns/100ps
`default_nettype none

module router_tile
    import router_pkg::*;
#(
    parameter int FIFO_DEPTH = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  t_tile_id          local_tile_id,
    input  logic        [4:0] in_valid,
    input  t_tile_trans [4:0] in_trans,
    input  t_fab_ready  [4:0] out_ready,
    output t_fab_ready  [4:0] in_ready,
    output logic        [4:0] out_valid,
    output t_tile_trans [4:0] out_trans
);

    // all arrays indexed by t_port
    logic        [4:0] head_valid;
    t_tile_trans [4:0] head_trans;
    logic        [4:0] pop;
    logic        [4:0] load;
    t_tile_trans [4:0] load_trans;
    logic        [4:0] can_load;

    for (genvar p = 0; p < 5; p++) begin : g_port
        tile_in_buffer #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_in_buffer (
            .clk        (clk),
            .reset      (reset),
            .in_valid   (in_valid[p]),
            .in_trans   (in_trans[p]),
            .pop        (pop[p]),
            .in_ready   (in_ready[p]),
            .head_valid (head_valid[p]),
            .head_trans (head_trans[p])
        );

        tile_out_reg u_out_reg (
            .clk        (clk),
            .reset      (reset),
            .load       (load[p]),
            .load_trans (load_trans[p]),
            .out_ready  (out_ready[p]),
            .can_load   (can_load[p]),
            .out_valid  (out_valid[p]),
            .out_trans  (out_trans[p])
        );
    end

    // pop goes back to the buffers, load forward to the output registers
    tile_switch u_switch (
        .clk           (clk),
        .reset         (reset),
        .local_tile_id (local_tile_id),
        .head_valid    (head_valid),
        .head_trans    (head_trans),
        .out_can_load  (can_load),
        .pop           (pop),
        .load          (load),
        .load_trans    (load_trans)
    );

endmodule

`default_nettype wire

/* rtl/tile_in_buffer.sv */
// circular FIFO for one tile input port with upstream ready
`timescale 1ns/100ps
`default_nettype none

module tile_in_buffer
    import router_pkg::*;
#(
    parameter int FIFO_DEPTH = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  t_tile_trans in_trans,
    input  logic        pop,
    output t_fab_ready  in_ready,
    output logic        head_valid,
    output t_tile_trans head_trans
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    t_tile_trans        mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;

    // ready only looks at occupancy, never at valid
    assign in_ready   = (count != CNT_W'(FIFO_DEPTH));
    assign push       = in_valid && in_ready;
    assign head_valid = (count != '0);
    assign head_trans = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_trans;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count as it is
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/tile_out_reg.sv */
// output holding register of one tile port
`timescale 1ns/100ps
`default_nettype none

module tile_out_reg
    import router_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        load,
    input  t_tile_trans load_trans,
    input  t_fab_ready  out_ready,
    output logic        can_load,
    output logic        out_valid,
    output t_tile_trans out_trans
);

    // free when empty or being drained this cycle
    assign can_load = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // held until the downstream side takes it
    always_ff @(posedge clk) begin
        if (load) begin
            out_trans <= load_trans;
        end
    end

endmodule

`default_nettype wire

/* rtl/tile_switch.sv */
// XY route selection and per-output round-robin arbiter of a router tile
`timescale 1ns/100ps
`default_nettype none

module tile_switch
    import router_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  t_tile_id          local_tile_id,
    input  logic        [4:0] head_valid,
    input  t_tile_trans [4:0] head_trans,
    input  logic        [4:0] out_can_load,
    output logic        [4:0] pop,
    output logic        [4:0] load,
    output t_tile_trans [4:0] load_trans
);

    t_port       [4:0] head_port;
    logic [4:0][2:0]   rr_ptr;
    logic [4:0][2:0]   win_idx;

    // dimension order, column first then row
    function automatic t_port route_port(t_tile_id target, t_tile_id own);
        t_port dir;
        if (target.col > own.col) begin
            dir = port_east;
        end else if (target.col < own.col) begin
            dir = port_west;
        end else if (target.row < own.row) begin
            dir = port_north;
        end else if (target.row > own.row) begin
            dir = port_south;
        end else begin
            dir = port_local;
        end
        return dir;
    endfunction

    always_comb begin
        for (int i = 0; i < 5; i++) begin
            head_port[i] = route_port(head_trans[i].target, local_tile_id);
        end
    end

    // each output scans inputs starting at its pointer
    always_comb begin
        int idx;
        pop        = '0;
        load       = '0;
        load_trans = '0;
        win_idx    = '0;
        idx        = 0;
        for (int o = 0; o < 5; o++) begin
            for (int k = 0; k < 5; k++) begin
                idx = int'(rr_ptr[o]) + k;
                if (idx >= 5) begin
                    idx = idx - 5;
                end
                if (!load[o] && out_can_load[o] && head_valid[idx] &&
                    head_port[idx] == t_port'(o)) begin
                    load[o]       = 1'b1;
                    load_trans[o] = head_trans[idx];
                    pop[idx]      = 1'b1;
                    win_idx[o]    = 3'(idx);
                end
            end
        end
    end

    // pointer moves just past the winner so a waiting input goes next
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
        end else begin
            for (int o = 0; o < 5; o++) begin
                if (load[o]) begin
                    rr_ptr[o] <= (win_idx[o] == 3'd4) ? 3'd0 : win_idx[o] + 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the fabric testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module fabric_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vfabric_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* sim.f */
rtl/router_pkg.sv
rtl/tile_in_buffer.sv
rtl/tile_switch.sv
rtl/tile_out_reg.sv
rtl/router_tile.sv
rtl/fabric.sv
verif/fabric_tb.sv

/* verif/fabric_tb.sv */
// clock, reset, LFSR stimulus, scoreboard queues and checks for the fabric testbench
`timescale 1ns/100ps
`default_nettype none

module fabric_tb
    import router_pkg::*;
();

    logic clk = 1'b0;
    logic reset;
    logic        [GRID_DIM:1][GRID_DIM:1] local_in_valid;
    t_tile_trans [GRID_DIM:1][GRID_DIM:1] local_in_trans;
    t_fab_ready  [GRID_DIM:1][GRID_DIM:1] local_out_ready;
    t_fab_ready  [GRID_DIM:1][GRID_DIM:1] local_in_ready;
    logic        [GRID_DIM:1][GRID_DIM:1] local_out_valid;
    t_tile_trans [GRID_DIM:1][GRID_DIM:1] local_out_trans;

    // scoreboard with one queue per destination and source pair
    t_tile_trans exp_q [81][$];
    int          last_seq [81];
    int          inj_cycle [81];
    int          inj_count [9];
    int          issued [9];
    int          seq_next [9];
    int          left [9];
    int          outstanding;
    int          cycle;
    int          err_count;
    int          timeout_count;
    logic        reset_check;
    logic        lat_mode;
    logic        fair_mode;
    int          fair_last;
    logic [8:0]  prev_hold;
    t_tile_trans prev_out [9];
    logic [31:0] lfsr;

    fabric u_dut (
        .clk             (clk),
        .reset           (reset),
        .local_in_valid  (local_in_valid),
        .local_in_trans  (local_in_trans),
        .local_out_ready (local_out_ready),
        .local_in_ready  (local_in_ready),
        .local_out_valid (local_out_valid),
        .local_out_trans (local_out_trans)
    );

    always #5 clk = ~clk;

    function automatic int tidx(int c, int r);
        return (c - 1) * 3 + (r - 1);
    endfunction

    // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int left_total();
        int s;
        s = 0;
        for (int i = 0; i < 9; i++) begin
            s += left[i];
        end
        return s;
    endfunction

    task automatic offer(input int sc, input int sr, input int dc, input int dr);
        int          t;
        t_tile_trans x;
        t = tidx(sc, sr);
        seq_next[t]++;
        issued[t]++;
        x.target  = '{col: 4'(dc), row: 4'(dr)};
        x.source  = '{col: 4'(sc), row: 4'(sr)};
        x.opcode  = t_opcode'(2'(rand_bits(2)));
        x.address = 16'(rand_bits(16));
        x.data    = rand_bits(32);
        x.seq     = 8'(seq_next[t]);
        local_in_trans[sc][sr] = x;
        local_in_valid[sc][sr] = 1'b1;
    endtask

    // drop valid once the monitor has seen the transfer
    task automatic release_accepted();
        for (int c = 1; c <= GRID_DIM; c++) begin
            for (int r = 1; r <= GRID_DIM; r++) begin
                if (local_in_valid[c][r] && inj_count[tidx(c, r)] == issued[tidx(c, r)]) begin
                    local_in_valid[c][r] = 1'b0;
                end
            end
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((local_in_valid != '0 || outstanding != 0) && n < limit) begin
            @(negedge clk);
            release_accepted();
            n++;
        end
        if (local_in_valid != '0 || outstanding != 0) begin
            timeout_count++;
            $display("timeout: %0d transactions still outstanding after %0d cycles",
                     outstanding, limit);
        end
    endtask

    task automatic send_one(input int sc, input int sr, input int dc, input int dr);
        @(negedge clk);
        offer(sc, sr, dc, dr);
        wait_drain(100);
    endtask

    always @(posedge clk) begin
        int          t;
        int          p;
        int          hops;
        int          other;
        t_tile_trans got;
        t_tile_trans want;
        if (reset_check) begin
            assert (local_out_valid == '0) else begin
                err_count++;
                $display("ERROR local_out_valid = %h, expected %h", local_out_valid, 9'h0);
            end
            assert (local_in_ready == '1) else begin
                err_count++;
                $display("ERROR local_in_ready = %h, expected %h", local_in_ready, 9'h1ff);
            end
        end
        if (!reset) begin
            for (int c = 1; c <= GRID_DIM; c++) begin
                for (int r = 1; r <= GRID_DIM; r++) begin
                    t = tidx(c, r);
                    // a stalled output must hold its transaction
                    if (prev_hold[t]) begin
                        assert (local_out_valid[c][r]) else begin
                            err_count++;
                            $display("ERROR local_out_valid[%0d][%0d] = %h, expected %h",
                                     c, r, local_out_valid[c][r], 1'b1);
                        end
                        assert (local_out_trans[c][r] == prev_out[t]) else begin
                            err_count++;
                            $display("ERROR local_out_trans[%0d][%0d] = %h, expected %h",
                                     c, r, local_out_trans[c][r], prev_out[t]);
                        end
                    end
                    prev_hold[t] = local_out_valid[c][r] && !local_out_ready[c][r];
                    prev_out[t]  = local_out_trans[c][r];
                    if (local_in_valid[c][r] && local_in_ready[c][r]) begin
                        got = local_in_trans[c][r];
                        p = tidx(int'(got.target.col), int'(got.target.row)) * 9 + t;
                        exp_q[p].push_back(got);
                        inj_cycle[p] = cycle;
                        inj_count[t]++;
                        outstanding++;
                    end
                    if (local_out_valid[c][r] && local_out_ready[c][r]) begin
                        got = local_out_trans[c][r];
                        assert (got.target == t_tile_id'{col: 4'(c), row: 4'(r)}) else begin
                            err_count++;
                            $display("ERROR local_out_trans[%0d][%0d].target = %h, expected %h",
                                     c, r, got.target, {4'(c), 4'(r)});
                        end
                        p = t * 9 + tidx(int'(got.source.col), int'(got.source.row));
                        assert (p >= 0 && p < 81 && exp_q[p].size() != 0) else begin
                            err_count++;
                            $display("tile %0d,%0d delivered a transaction nobody injected",
                                     c, r);
                        end
                        if (p >= 0 && p < 81 && exp_q[p].size() != 0) begin
                            want = exp_q[p].pop_front();
                            outstanding--;
                            assert (got == want) else begin
                                err_count++;
                                $display("ERROR local_out_trans[%0d][%0d] = %h, expected %h",
                                         c, r, got, want);
                            end
                            assert (int'(got.seq) > last_seq[p]) else begin
                                err_count++;
                                $display("ERROR seq = %h, expected above %h",
                                         got.seq, last_seq[p]);
                            end
                            last_seq[p] = int'(got.seq);
                            if (lat_mode) begin
                                hops = (c > int'(got.source.col)) ? c - int'(got.source.col)
                                                                  : int'(got.source.col) - c;
                                hops += (r > int'(got.source.row)) ? r - int'(got.source.row)
                                                                   : int'(got.source.row) - r;
                                assert (cycle - inj_cycle[p] == 2 * (hops + 1)) else begin
                                    err_count++;
                                    $display("ERROR latency = %h, expected %h",
                                             cycle - inj_cycle[p], 2 * (hops + 1));
                                end
                            end
                            // shared output at 2,2 must alternate between its two feeders
                            if (fair_mode && c == 2 && r == 2) begin
                                other = (got.source.col == 4'd1) ? 3 : 1;
                                assert (!(int'(got.source.col) == fair_last
                                          && exp_q[t * 9 + tidx(other, 2)].size() != 0))
                                else begin
                                    err_count++;
                                    $display("source %0d,2 won twice while %0d,2 was waiting",
                                             got.source.col, other);
                                end
                                fair_last = int'(got.source.col);
                            end
                        end
                    end
                end
            end
        end
        if (!fair_mode) begin
            fair_last = 0;
        end
        cycle++;
    end

    initial begin
        int n;
        reset           = 1'b1;
        reset_check     = 1'b0;
        lat_mode        = 1'b0;
        fair_mode       = 1'b0;
        prev_hold       = '0;
        local_in_valid  = '0;
        local_in_trans  = '0;
        local_out_ready = '1;
        lfsr            = 32'h4f7b;
        @(negedge clk);
        reset_check = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        reset_check = 1'b0;

        // one transaction at a time through the idle fabric
        lat_mode = 1'b1;
        send_one(1, 1, 1, 1);
        send_one(1, 1, 3, 3);
        send_one(2, 2, 2, 1);
        send_one(3, 1, 1, 2);
        send_one(2, 3, 3, 2);
        lat_mode = 1'b0;

        // random traffic from every tile with random ready
        for (int i = 0; i < 9; i++) begin
            left[i] = 20;
        end
        n = 0;
        while ((left_total() != 0 || local_in_valid != '0) && n < 3000) begin
            @(negedge clk);
            release_accepted();
            for (int c = 1; c <= GRID_DIM; c++) begin
                for (int r = 1; r <= GRID_DIM; r++) begin
                    if (!local_in_valid[c][r] && left[tidx(c, r)] > 0 &&
                        rand_bits(1) != 0) begin
                        offer(c, r, int'(rand_bits(2) % 3) + 1, int'(rand_bits(2) % 3) + 1);
                        left[tidx(c, r)]--;
                    end
                    local_out_ready[c][r] = 1'(rand_bits(1));
                end
            end
            n++;
        end
        if (left_total() != 0 || local_in_valid != '0) begin
            timeout_count++;
            $display("timeout: random injection did not finish");
        end
        local_out_ready = '1;
        wait_drain(500);

        // back-pressure at tile 3,3 fed from 1,3
        local_out_ready[3][3] = 1'b0;
        n = 0;
        while (local_in_ready[1][3] && n < 200) begin
            @(negedge clk);
            release_accepted();
            if (!local_in_valid[1][3]) begin
                offer(1, 3, 3, 3);
            end
            n++;
        end
        if (local_in_ready[1][3]) begin
            timeout_count++;
            $display("timeout: injection at tile 1,3 never stalled");
        end
        repeat (10) begin
            @(negedge clk);
            release_accepted();
        end
        local_out_ready[3][3] = 1'b1;
        wait_drain(300);

        // two neighbours streaming into tile 2,2
        fair_mode = 1'b1;
        left[tidx(1, 2)] = 16;
        left[tidx(3, 2)] = 16;
        n = 0;
        while ((left_total() != 0 || local_in_valid != '0) && n < 300) begin
            @(negedge clk);
            release_accepted();
            for (int c = 1; c <= GRID_DIM; c += 2) begin
                if (!local_in_valid[c][2] && left[tidx(c, 2)] > 0) begin
                    offer(c, 2, 2, 2);
                    left[tidx(c, 2)]--;
                end
            end
            n++;
        end
        if (left_total() != 0 || local_in_valid != '0) begin
            timeout_count++;
            $display("timeout: contending streams did not finish");
        end
        wait_drain(200);
        fair_mode = 1'b0;

        $display("errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
